// File: Bender.yml
package:
  name: racc_ring

sources:
  # Packages first, then the RTL from the leaf up
  - source/raccPkg.sv
  - source/ramPkg.sv
  - source/raccRamBridge.sv
  - source/sharedRam.sv
  - source/ringTop.sv
  # Testbench
  - target: test
    files:
      - verification/clockGen.sv
      - verification/ringTopTb.sv

// File: source/raccPkg.sv
// Raccoon ring packet package with slot field types and the node address window mask
package raccPkg;

  // Field widths of one ring slot
  // Together with valid, isResp and isWrite they fill an 80-bit slot
  localparam int raccAddrBits = 32;
  localparam int raccDataBits = 32;
  localparam int raccSrcBits  = 4;
  localparam int raccTagBits  = 5;

  // One write enable per byte of the data word
  localparam int raccMaskBits = raccDataBits / 8;

  // Byte address carried by every request and response
  typedef logic [raccAddrBits-1:0] raccAddrT;

  // Write data on requests, read data or echoed write data on responses
  typedef logic [raccDataBits-1:0] raccDataT;

  // Byte-lane write enables where bit i selects byte i of the data word
  typedef logic [raccMaskBits-1:0] raccMaskT;

  // Identifies the requester that launched the packet
  typedef logic [raccSrcBits-1:0] raccSrcT;

  // Lets a requester match responses to its outstanding requests
  typedef logic [raccTagBits-1:0] raccTagT;

  // Upper address bits that select a node
  // A node owns the request when the masked address equals its base
  // The lower 16 bits are left for the word index and byte offset inside the node
  localparam raccAddrT raccWindowMask = 32'hFFFF_0000;

endpackage : raccPkg

// File: source/raccRamBridge.sv
// Ring node bridge that serves requests in its address window from a RAM port
`timescale 1ns/1ns

module raccRamBridge
  import raccPkg::*;
  import ramPkg::*;
#(
  parameter raccAddrT addrBase = 32'h0001_0000
) (
  input  logic     CLK,
  input  logic     rstN,

  // Slot arriving from upstream
  input  logic     inValid,
  input  logic     inIsResp,
  input  logic     inIsWrite,
  input  raccSrcT  inSrcId,
  input  raccTagT  inTag,
  input  raccMaskT inMask,
  input  raccAddrT inAddr,
  input  raccDataT inData,

  // Slot leaving downstream
  output logic     outValid,
  output logic     outIsResp,
  output logic     outIsWrite,
  output raccSrcT  outSrcId,
  output raccTagT  outTag,
  output raccMaskT outMask,
  output raccAddrT outAddr,
  output raccDataT outData,

  // RAM port whose read data returns one cycle after ramSel
  output logic     ramSel,
  output logic     ramWrite,
  output ramIndexT ramIndex,
  output ramLaneT  ramLanes,
  output raccDataT ramWrData,
  input  raccDataT ramRdData
);

  // Stage 1 holds the slot while the window is checked and the RAM is accessed
  logic     s1Valid;
  logic     s1IsResp;
  logic     s1IsWrite;
  raccSrcT  s1SrcId;
  raccTagT  s1Tag;
  raccMaskT s1Mask;
  raccAddrT s1Addr;
  raccDataT s1Data;
  logic     s1Hit;

  // Stage 2 holds the slot while the RAM read data comes back
  logic     s2Valid;
  logic     s2IsResp;
  logic     s2IsWrite;
  logic     s2Served;
  raccSrcT  s2SrcId;
  raccTagT  s2Tag;
  raccMaskT s2Mask;
  raccAddrT s2Addr;
  raccDataT s2Data;

  // Stage 1 valid flag
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;
    end
  end

  always_ff @(posedge CLK) begin
    s1IsResp  <= inIsResp;
    s1IsWrite <= inIsWrite;
    s1SrcId   <= inSrcId;
    s1Tag     <= inTag;
    s1Mask    <= inMask;
    s1Addr    <= inAddr;
    s1Data    <= inData;
  end

  // A live request whose masked address lands on this node's base
  assign s1Hit = s1Valid && !s1IsResp && ((s1Addr & raccWindowMask) == addrBase);

  // The RAM sees the request in the same cycle the match is made
  assign ramSel    = s1Hit;
  assign ramWrite  = s1Hit && s1IsWrite;
  assign ramIndex  = s1Addr[ramIndexLsb +: ramIndexBits];
  assign ramLanes  = ramLaneT'(s1Mask);
  assign ramWrData = s1Data;

  // Served marks the slots that leave as responses built by this node
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      s2Valid  <= 1'b0;
      s2Served <= 1'b0;
    end else begin
      s2Valid  <= s1Valid;
      s2Served <= s1Hit;
    end
  end

  always_ff @(posedge CLK) begin
    s2IsResp  <= s1IsResp;
    s2IsWrite <= s1IsWrite;
    s2SrcId   <= s1SrcId;
    s2Tag     <= s1Tag;
    s2Mask    <= s1Mask;
    s2Addr    <= s1Addr;
    s2Data    <= s1Data;
  end

  // Routing, tag and mask fields always pass unchanged
  assign outValid   = s2Valid;
  assign outIsWrite = s2IsWrite;
  assign outSrcId   = s2SrcId;
  assign outTag     = s2Tag;
  assign outMask    = s2Mask;
  assign outAddr    = s2Addr;

  // A served slot turns into a response
  assign outIsResp = s2IsResp || s2Served;

  // Served reads take the RAM word
  // Writes and passed slots keep the data they came with
  assign outData = (s2Served && !s2IsWrite) ? ramRdData : s2Data;

  // A response leaving this node either came in as one or hit this window two cycles before
  assert property (@(posedge CLK) disable iff (!rstN)
    outValid && outIsResp |->
      $past(inValid && (inIsResp || ((inAddr & raccWindowMask) == addrBase)), 2));

  // Every RAM access comes out in the next cycle as a response of the same kind
  assert property (@(posedge CLK) disable iff (!rstN)
    ramSel |=> outValid && outIsResp && (outIsWrite == $past(ramWrite)));

endmodule : raccRamBridge

// File: source/ramPkg.sv
// Node memory package with array depth, word index and byte lane types
package ramPkg;

  // Width of one byte lane and number of lanes in a word
  localparam int ramByteBits  = 8;
  localparam int ramLaneCount = 4;

  // The array holds 2**ramIndexBits words
  localparam int ramIndexBits = 14;
  localparam int ramDepth     = 1 << ramIndexBits;

  // Byte address bit where the word index starts
  // The bits below select a byte inside the word and are ignored by the RAM
  localparam int ramIndexLsb = $clog2(ramLaneCount);

  // Word index into the array from address bits 15 down to 2
  typedef logic [ramIndexBits-1:0] ramIndexT;

  // Per-byte write enable inside the RAM with the same meaning as the ring mask
  typedef logic [ramLaneCount-1:0] ramLaneT;

endpackage : ramPkg

// File: source/ringTop.sv
// Ring segment with two shared memory nodes in series
`timescale 1ns/1ns

module ringTop
  import raccPkg::*;
(
  input  logic     CLK,
  input  logic     rstN,

  input  logic     inValid,
  input  logic     inIsResp,
  input  logic     inIsWrite,
  input  raccSrcT  inSrcId,
  input  raccTagT  inTag,
  input  raccMaskT inMask,
  input  raccAddrT inAddr,
  input  raccDataT inData,

  output logic     outValid,
  output logic     outIsResp,
  output logic     outIsWrite,
  output raccSrcT  outSrcId,
  output raccTagT  outTag,
  output raccMaskT outMask,
  output raccAddrT outAddr,
  output raccDataT outData
);

  // Ring slot between node0 and node1
  logic     midValid;
  logic     midIsResp;
  logic     midIsWrite;
  raccSrcT  midSrcId;
  raccTagT  midTag;
  raccMaskT midMask;
  raccAddrT midAddr;
  raccDataT midData;

  // First node owns the 64 KB window at 0001_0000
  sharedRam #(
    .addrBase (32'h0001_0000)
  ) node0 (
    .CLK        (CLK),
    .rstN       (rstN),
    .inValid    (inValid),
    .inIsResp   (inIsResp),
    .inIsWrite  (inIsWrite),
    .inSrcId    (inSrcId),
    .inTag      (inTag),
    .inMask     (inMask),
    .inAddr     (inAddr),
    .inData     (inData),
    .outValid   (midValid),
    .outIsResp  (midIsResp),
    .outIsWrite (midIsWrite),
    .outSrcId   (midSrcId),
    .outTag     (midTag),
    .outMask    (midMask),
    .outAddr    (midAddr),
    .outData    (midData)
  );

  // Second node owns the window at 0002_0000 and sees node0 responses as pass-through
  sharedRam #(
    .addrBase (32'h0002_0000)
  ) node1 (
    .CLK        (CLK),
    .rstN       (rstN),
    .inValid    (midValid),
    .inIsResp   (midIsResp),
    .inIsWrite  (midIsWrite),
    .inSrcId    (midSrcId),
    .inTag      (midTag),
    .inMask     (midMask),
    .inAddr     (midAddr),
    .inData     (midData),
    .outValid   (outValid),
    .outIsResp  (outIsResp),
    .outIsWrite (outIsWrite),
    .outSrcId   (outSrcId),
    .outTag     (outTag),
    .outMask    (outMask),
    .outAddr    (outAddr),
    .outData    (outData)
  );

endmodule : ringTop

// File: source/sharedRam.sv
// Ring memory node with a bridge and a byte-maskable synchronous RAM
`timescale 1ns/1ns

module sharedRam
  import raccPkg::*;
  import ramPkg::*;
#(
  parameter raccAddrT addrBase = 32'h0001_0000
) (
  input  logic     CLK,
  input  logic     rstN,

  input  logic     inValid,
  input  logic     inIsResp,
  input  logic     inIsWrite,
  input  raccSrcT  inSrcId,
  input  raccTagT  inTag,
  input  raccMaskT inMask,
  input  raccAddrT inAddr,
  input  raccDataT inData,

  output logic     outValid,
  output logic     outIsResp,
  output logic     outIsWrite,
  output raccSrcT  outSrcId,
  output raccTagT  outTag,
  output raccMaskT outMask,
  output raccAddrT outAddr,
  output raccDataT outData
);

  // RAM port between the bridge and the array
  logic     ramSel;
  logic     ramWrite;
  ramIndexT ramIndex;
  ramLaneT  ramLanes;
  raccDataT ramWrData;
  raccDataT ramRdData;

  // Word storage of this node
  raccDataT memArray [ramDepth];

  raccRamBridge #(
    .addrBase (addrBase)
  ) u_raccRamBridge (
    .CLK        (CLK),
    .rstN       (rstN),
    .inValid    (inValid),
    .inIsResp   (inIsResp),
    .inIsWrite  (inIsWrite),
    .inSrcId    (inSrcId),
    .inTag      (inTag),
    .inMask     (inMask),
    .inAddr     (inAddr),
    .inData     (inData),
    .outValid   (outValid),
    .outIsResp  (outIsResp),
    .outIsWrite (outIsWrite),
    .outSrcId   (outSrcId),
    .outTag     (outTag),
    .outMask    (outMask),
    .outAddr    (outAddr),
    .outData    (outData),
    .ramSel     (ramSel),
    .ramWrite   (ramWrite),
    .ramIndex   (ramIndex),
    .ramLanes   (ramLanes),
    .ramWrData  (ramWrData),
    .ramRdData  (ramRdData)
  );

  // Only the enabled byte lanes are written and the others keep their old contents
  always_ff @(posedge CLK) begin
    if (ramSel && ramWrite) begin
      for (int lane = 0; lane < ramLaneCount; lane++) begin
        if (ramLanes[lane]) begin
          memArray[ramIndex][lane*ramByteBits +: ramByteBits] <=
            ramWrData[lane*ramByteBits +: ramByteBits];
        end
      end
    end
  end

  // Every select reads the word
  // A write returns the word as it was before the merge
  always_ff @(posedge CLK) begin
    if (ramSel) begin
      ramRdData <= memArray[ramIndex];
    end
  end

  // The index built by the bridge must be known whenever the array is touched
  assert property (@(posedge CLK) disable iff (!rstN)
    ramSel |-> !$isunknown(ramIndex));

endmodule : sharedRam

// File: tb.f
source/raccPkg.sv
source/ramPkg.sv
source/raccRamBridge.sv
source/sharedRam.sv
source/ringTop.sv
verification/clockGen.sv
verification/ringTopTb.sv

// File: verification/clockGen.sv
// Testbench clock and reset source for the ring with a fixed period and a held reset
`timescale 1ns/1ns

module clockGen #(
  parameter int periodNs    = 4,
  parameter int resetCycles = 5
) (
  output logic CLK,
  output logic rstN
);

  // Free-running clock whose first rising edge comes half a period after time zero
  initial begin
    CLK = 1'b0;
    forever begin
      #(periodNs / 2) CLK = ~CLK;
    end
  end

  // Reset is released on a falling edge so it never races the rising edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge CLK);
    @(negedge CLK);
    rstN = 1'b1;
  end

endmodule : clockGen

// File: verification/ringTopTb.sv
// Table-driven testbench for the two-node ring with a reference memory model
`timescale 1ns/1ns

module ringTopTb
  import raccPkg::*;
  import ramPkg::*;
();

  localparam int periodNs    = 4;
  localparam int resetCycles = 5;
  // Two nodes of two stages each between the ring input and output
  localparam int ringLatency = 4;
  localparam int marginCycles = 20;
  localparam raccAddrT base0 = 32'h0001_0000;
  localparam raccAddrT base1 = 32'h0002_0000;

  typedef enum logic [1:0] {slotNode0, slotNode1, slotPass, slotEmpty} slotClassT;

  // One ring slot together with the node that is expected to handle it
  typedef struct packed {
    logic      valid;
    logic      isResp;
    logic      isWrite;
    raccSrcT   srcId;
    raccTagT   tag;
    raccMaskT  mask;
    raccAddrT  addr;
    raccDataT  data;
    slotClassT cls;
  } slotT;

  logic     CLK;
  logic     rstN;
  logic     inValid;
  logic     inIsResp;
  logic     inIsWrite;
  raccSrcT  inSrcId;
  raccTagT  inTag;
  raccMaskT inMask;
  raccAddrT inAddr;
  raccDataT inData;
  logic     outValid;
  logic     outIsResp;
  logic     outIsWrite;
  raccSrcT  outSrcId;
  raccTagT  outTag;
  raccMaskT outMask;
  raccAddrT outAddr;
  raccDataT outData;

  slotT        stimTable[$];
  slotT        expQueue[$];
  raccDataT    refMem0 [ramIndexT];
  raccDataT    refMem1 [ramIndexT];
  logic [31:0] rngState = 32'h4baf_5923;
  logic        tableReady = 1'b0;

  clockGen #(.periodNs(periodNs), .resetCycles(resetCycles)) u_clockGen (
    .CLK (CLK), .rstN (rstN)
  );

  ringTop u_ringTop (
    .CLK (CLK), .rstN (rstN),
    .inValid (inValid), .inIsResp (inIsResp), .inIsWrite (inIsWrite), .inSrcId (inSrcId),
    .inTag (inTag), .inMask (inMask), .inAddr (inAddr), .inData (inData),
    .outValid (outValid), .outIsResp (outIsResp), .outIsWrite (outIsWrite),
    .outSrcId (outSrcId), .outTag (outTag), .outMask (outMask), .outAddr (outAddr),
    .outData (outData)
  );

  // Xorshift generator that advances one step per call
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // Bytes with a set mask bit come from the new word and the rest keep the old value
  function automatic raccDataT mergeBytes(raccDataT oldWord, raccDataT newWord, raccMaskT mask);
    raccDataT merged;
    merged = oldWord;
    for (int lane = 0; lane < 4; lane++) begin
      if (mask[lane]) merged[lane*8 +: 8] = newWord[lane*8 +: 8];
    end
    return merged;
  endfunction

  task automatic stopOnError(string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkValid(string name, bit actual, bit expected);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h got %h", name, expected, actual);
      stopOnError("Slot field differs from the reference");
    end
  endtask

  task automatic checkAddr(string name, raccAddrT actual, raccAddrT expected);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h got %h", name, expected, actual);
      stopOnError("Slot address differs from the reference");
    end
  endtask

  task automatic checkData(string name, raccDataT actual, raccDataT expected);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h got %h", name, expected, actual);
      stopOnError("Slot data differs from the reference");
    end
  endtask

  // Appends one table row
  // The tag numbers the rows so a slip in order shows up
  task automatic addEntry(slotClassT cls, logic isResp, logic isWrite, raccMaskT mask,
                          raccAddrT addr, raccDataT data);
    slotT s;
    s.cls     = cls;
    s.valid   = (cls != slotEmpty);
    s.isResp  = isResp;
    s.isWrite = isWrite;
    s.srcId   = raccSrcT'(nextRandom());
    s.tag     = raccTagT'(stimTable.size());
    s.mask    = mask;
    s.addr    = addr;
    s.data    = data;
    stimTable.push_back(s);
  endtask

  task automatic buildTable();
    raccMaskT    pm;
    logic [31:0] r;
    logic        prevWrite;
    raccAddrT    prevAddr;
    slotClassT   cls;
    // Idle slots where the middle one carries stale write fields
    addEntry(slotEmpty, 1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
    addEntry(slotEmpty, 1'b0, 1'b1, 4'hF, base0, 32'hDEAD_BEEF);
    addEntry(slotEmpty, 1'b0, 1'b0, 4'h0, 32'h0, 32'h0);
    // Full words at the same offsets in both windows and then read back
    for (int i = 0; i < 8; i++) begin
      addEntry(slotNode0, 1'b0, 1'b1, 4'hF, base0 + 4 * i, nextRandom());
      addEntry(slotNode1, 1'b0, 1'b1, 4'hF, base1 + 4 * i, nextRandom());
    end
    for (int i = 0; i < 8; i++) begin
      addEntry(slotNode0, 1'b0, 1'b0, 4'hF, base0 + 4 * i, 32'h0);
      addEntry(slotNode1, 1'b0, 1'b0, 4'hF, base1 + 4 * i, 32'h0);
    end
    // Partial masks never all set and never all clear
    for (int i = 0; i < 4; i++) begin
      pm = raccMaskT'(nextRandom());
      if (pm == 4'hF || pm == 4'h0) pm = 4'h5;
      addEntry(slotNode0, 1'b0, 1'b1, pm, base0 + 4 * i, nextRandom());
      addEntry(slotNode1, 1'b0, 1'b1, ~pm, base1 + 4 * (i + 4), nextRandom());
    end
    for (int i = 0; i < 4; i++) begin
      addEntry(slotNode0, 1'b0, 1'b0, 4'hF, base0 + 4 * i, 32'h0);
      addEntry(slotNode1, 1'b0, 1'b0, 4'hF, base1 + 4 * (i + 4), 32'h0);
    end
    // Requests outside both windows, responses already on the ring and a junk empty slot
    addEntry(slotPass, 1'b0, 1'b0, 4'hF, 32'h0003_0010, nextRandom());
    addEntry(slotPass, 1'b0, 1'b1, 4'h3, 32'h0000_FFFC, nextRandom());
    addEntry(slotPass, 1'b0, 1'b1, 4'hF, 32'h8001_0000, nextRandom());
    addEntry(slotPass, 1'b1, 1'b0, 4'hF, base0 + 8, nextRandom());
    addEntry(slotPass, 1'b1, 1'b1, 4'hF, base1 + 8, nextRandom());
    addEntry(slotEmpty, 1'b0, 1'b1, 4'hF, base1 + 4, nextRandom());
    // Words that a wrongly served write among the slots above would have changed
    addEntry(slotNode0, 1'b0, 1'b0, 4'hF, base0, 32'h0);
    addEntry(slotNode1, 1'b0, 1'b0, 4'hF, base1 + 8, 32'h0);
    addEntry(slotNode1, 1'b0, 1'b0, 4'hF, base1 + 4, 32'h0);
    // Partial writes read back in the very next slot of the same node
    addEntry(slotNode0, 1'b0, 1'b1, 4'h9, base0 + 12, nextRandom());
    addEntry(slotNode0, 1'b0, 1'b0, 4'hF, base0 + 12, 32'h0);
    addEntry(slotNode1, 1'b0, 1'b1, 4'h6, base1 + 20, nextRandom());
    addEntry(slotNode1, 1'b0, 1'b0, 4'hF, base1 + 20, 32'h0);
    // Random mix over the written words that sometimes reads right behind a write
    prevWrite = 1'b0;
    prevAddr  = base0;
    for (int k = 0; k < 60; k++) begin
      r = nextRandom();
      if (prevWrite && r[5]) begin
        cls = (prevAddr[17]) ? slotNode1 : slotNode0;
        addEntry(cls, 1'b0, 1'b0, 4'hF, prevAddr, 32'h0);
        prevWrite = 1'b0;
      end else begin
        cls      = r[0] ? slotNode1 : slotNode0;
        prevAddr = (r[0] ? base1 : base0) + 4 * r[3:1];
        addEntry(cls, 1'b0, r[4], r[11:8], prevAddr, nextRandom());
        prevWrite = r[4];
      end
    end
  endtask

  // Works out the slot expected at the ring output and updates the model memories
  task automatic predictSlot(input slotT s, output slotT e);
    ramIndexT idx;
    raccDataT oldWord;
    e   = s;
    idx = ramIndexT'(s.addr >> 2);
    if (s.cls == slotNode0 || s.cls == slotNode1) begin
      e.isResp = 1'b1;
      if (s.cls == slotNode0) begin
        oldWord = refMem0.exists(idx) ? refMem0[idx] : 'x;
      end else begin
        oldWord = refMem1.exists(idx) ? refMem1[idx] : 'x;
      end
      if (s.isWrite) begin
        if (s.cls == slotNode0) refMem0[idx] = mergeBytes(oldWord, s.data, s.mask);
        else refMem1[idx] = mergeBytes(oldWord, s.data, s.mask);
      end else if ($isunknown(oldWord)) begin
        stopOnError("The stimulus table reads a word that was never written");
      end else begin
        e.data = oldWord;
      end
    end
  endtask

  task automatic checkSlot();
    slotT e;
    e = expQueue.pop_front();
    checkValid("outValid", outValid, e.valid);
    if (e.valid) begin
      checkValid("outIsResp", outIsResp, e.isResp);
      checkValid("outIsWrite", outIsWrite, e.isWrite);
      checkData("outSrcId", raccDataT'(outSrcId), raccDataT'(e.srcId));
      checkData("outTag", raccDataT'(outTag), raccDataT'(e.tag));
      checkData("outMask", raccDataT'(outMask), raccDataT'(e.mask));
      checkAddr("outAddr", outAddr, e.addr);
      checkData("outData", outData, e.data);
    end
  endtask

  task automatic driveSlot(slotT s);
    inValid   = s.valid;
    inIsResp  = s.isResp;
    inIsWrite = s.isWrite;
    inSrcId   = s.srcId;
    inTag     = s.tag;
    inMask    = s.mask;
    inAddr    = s.addr;
    inData    = s.data;
  endtask

  initial begin
    slotT e;
    driveSlot('0);
    buildTable();
    tableReady = 1'b1;
    // Nothing may leave the ring while reset is held
    repeat (resetCycles) begin
      @(negedge CLK);
      checkValid("outValid", outValid, 1'b0);
    end
    wait (rstN === 1'b1);
    // Each output is checked on the falling edge four cycles after its slot went in
    for (int c = 0; c < stimTable.size() + ringLatency; c++) begin
      @(negedge CLK);
      if (c >= ringLatency) checkSlot();
      else checkValid("outValid", outValid, 1'b0);
      if (c < stimTable.size()) begin
        driveSlot(stimTable[c]);
        predictSlot(stimTable[c], e);
        expQueue.push_back(e);
      end else begin
        driveSlot('0);
      end
    end
    $display("Simulation passed");
    $finish;
  end

  // Stops the run at twice the time that reset, the table and the pipeline drain take
  initial begin
    int limitNs;
    wait (tableReady);
    limitNs = (resetCycles + stimTable.size() + ringLatency + marginCycles) * periodNs * 2;
    #(limitNs);
    $display("The run took longer than %0d ns and was stopped", limitNs);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule : ringTopTb
